/* bench/evr_rx_wrapper_chk.sv */
/* Protocol assertions on the wrapper ports, bound into every evr_rx_wrapper instance.
   Failures count up in fail_cnt for the testbench summary. */

`timescale 1ns/1ps

module evr_rx_wrapper_chk (
    input logic                          evrClk,
    input logic                          arst_n_i,
    input evr_char_pkg::rx_lane_t        rx_lane_i,
    input logic                          ctrl_strobe_i,
    input logic [evr_mgt_pkg::CSR_W-1:0] ctrl_data_i,
    input evr_char_pkg::rx_word_t        chars_o,
    input logic                          rx_aligned_o,
    input evr_mgt_pkg::mgt_ctrl_t        mgt_ctrl_o,
    input logic                          bit_slide_o
);

    int unsigned fail_cnt = 0;
    logic        lane_err;

    // bad code group, disparity, or K outside byte 0
    assign lane_err = (|rx_lane_i.not_in_table) || (|rx_lane_i.disp_err)
                   || rx_lane_i.word.is_k[1];

    ////////////////////////////////////////////////////////////////////////////
    // character gating

    // nothing reaches the decoder unless locked a cycle earlier
    chars_need_lock: assert property (@(posedge evrClk) disable iff (!arst_n_i)
        (chars_o != '0) |-> $past(rx_aligned_o))
        else begin
            fail_cnt++;
            $error("chars_o nonzero without lock on the previous cycle");
        end

    error_drops_lock: assert property (@(posedge evrClk) disable iff (!arst_n_i)
        lane_err |=> (!rx_aligned_o && chars_o == '0))
        else begin
            fail_cnt++;
            $error("error word did not clear lock and chars_o");
        end

    ////////////////////////////////////////////////////////////////////////////
    // control side

    slide_single_cycle: assert property (@(posedge evrClk) disable iff (!arst_n_i)
        bit_slide_o |=> !bit_slide_o)
        else begin
            fail_cnt++;
            $error("bit_slide_o high for two cycles");
        end

    // control fields sit in bits 30..25 of the written word
    ctrl_follows_write: assert property (@(posedge evrClk) disable iff (!arst_n_i)
        ctrl_strobe_i |=> (mgt_ctrl_o == $past(ctrl_data_i[30:25])))
        else begin
            fail_cnt++;
            $error("mgt_ctrl_o does not match the strobed control bits");
        end

endmodule

bind evr_rx_wrapper evr_rx_wrapper_chk u_chk (
    .evrClk        (evrClk),
    .arst_n_i      (arst_n_i),
    .rx_lane_i     (rx_lane_i),
    .ctrl_strobe_i (ctrl_strobe_i),
    .ctrl_data_i   (ctrl_data_i),
    .chars_o       (chars_o),
    .rx_aligned_o  (rx_aligned_o),
    .mgt_ctrl_o    (mgt_ctrl_o),
    .bit_slide_o   (bit_slide_o)
);

/* bench/evr_rx_wrapper_tb.sv */
/* Testbench for the receive side wrapper. Drives the decoded lane, control writes and
   status levels, and checks every output against a cycle model and directed checks. */

`timescale 1ns/1ps

module evr_rx_wrapper_tb;

    import evr_char_pkg::*;
    import evr_mgt_pkg::*;

    localparam int MAX_CYCLES = 2000;   // stimulus runs ~650 cycles

    // dut ports
    logic             evrClk;
    logic             arst_n_i;
    rx_lane_t         rx_lane_i;
    logic             ctrl_strobe_i;
    logic [CSR_W-1:0] ctrl_data_i;
    mgt_stat_t        mgt_stat_i;
    rx_word_t         chars_o;
    logic             rx_aligned_o;
    mgt_ctrl_t        mgt_ctrl_o;
    logic             bit_slide_o;
    logic [CSR_W-1:0] status_o;

    // reference model
    logic             m_locked;
    int               m_cnt;        // commas still missing
    rx_word_t         m_chars;
    mgt_ctrl_t        m_ctrl;
    logic             m_req_prev;
    logic             m_slide;
    logic [CSR_W-1:0] m_status;

    string            test_name;
    int               model_errs;
    int               directed_errs;
    int               cycle_cnt;

    evr_rx_wrapper u_dut (
        .evrClk        (evrClk),
        .arst_n_i      (arst_n_i),
        .rx_lane_i     (rx_lane_i),
        .ctrl_strobe_i (ctrl_strobe_i),
        .ctrl_data_i   (ctrl_data_i),
        .mgt_stat_i    (mgt_stat_i),
        .chars_o       (chars_o),
        .rx_aligned_o  (rx_aligned_o),
        .mgt_ctrl_o    (mgt_ctrl_o),
        .bit_slide_o   (bit_slide_o),
        .status_o      (status_o)
    );

    always #4 evrClk = ~evrClk;     // 8 ns period

    ////////////////////////////////////////////////////////////////////////////
    // word helpers

    // decoder flag set, or K in byte 1
    function automatic bit is_error_word(rx_lane_t l);
        return (l.not_in_table != 2'b00) || (l.disp_err != 2'b00) || l.word.is_k[1];
    endfunction

    function automatic bit is_comma_word(rx_lane_t l);
        return !is_error_word(l) && l.word.is_k[0] && (l.word.data[7:0] == 8'hBC);
    endfunction

    function automatic rx_lane_t comma_word();
        rx_lane_t l;
        l = '0;
        l.word.data     = {8'($urandom), 8'hBC};   // upper byte is free data
        l.word.is_k     = 2'b01;
        l.word.is_comma = 2'b01;
        return l;
    endfunction

    // clean word that is never a comma
    function automatic rx_lane_t data_word();
        rx_lane_t l;
        l = '0;
        l.word.data     = 16'($urandom);
        l.word.is_k[0]  = 1'($urandom);
        l.word.is_comma = 2'($urandom);
        if (l.word.data[7:0] == 8'hBC) begin
            l.word.is_k[0] = 1'b0;
        end
        return l;
    endfunction

    function automatic rx_lane_t error_word();
        rx_lane_t l;
        int       kind;
        l    = data_word();
        kind = $urandom_range(2, 0);
        case (kind)
            0:       l.not_in_table = 2'($urandom_range(3, 1));
            1:       l.disp_err     = 2'($urandom_range(3, 1));
            default: l.word.is_k[1] = 1'b1;                   // K in the wrong byte
        endcase
        return l;
    endfunction

    function automatic bit values_match(string what, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // cycle model, inputs read before the edge

    always @(posedge evrClk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            m_locked   <= 1'b0;
            m_cnt      <= COMMAS_NEEDED;
            m_chars    <= '0;
            m_ctrl     <= '0;
            m_req_prev <= 1'b0;
            m_slide    <= 1'b0;
        end else begin
            m_chars <= (m_locked && !is_error_word(rx_lane_i)) ? rx_lane_i.word : '0;
            if (is_error_word(rx_lane_i)) begin
                m_locked <= 1'b0;
                m_cnt    <= COMMAS_NEEDED;
            end else if (!m_locked && is_comma_word(rx_lane_i)) begin
                m_cnt <= m_cnt - 1;
                if (m_cnt == 1) begin
                    m_locked <= 1'b1;       // lock on the last comma's edge
                end
            end
            if (ctrl_strobe_i) begin
                m_ctrl <= ctrl_data_i[30:25];
            end
            m_req_prev <= m_ctrl.slide_req;
            m_slide    <= m_ctrl.slide_req && !m_req_prev;
        end
    end

    always_comb begin
        m_status        = '0;
        m_status[30]    = m_locked;
        m_status[29:24] = mgt_stat_i;
    end

    // outputs settled by the falling edge
    always @(negedge evrClk) begin
        if (arst_n_i) begin
            if (!values_match("rx_aligned_o", {31'd0, m_locked}, {31'd0, rx_aligned_o}))
                model_errs++;
            if (!values_match("chars_o", {12'd0, m_chars}, {12'd0, chars_o}))
                model_errs++;
            if (!values_match("mgt_ctrl_o", {26'd0, m_ctrl}, {26'd0, mgt_ctrl_o}))
                model_errs++;
            if (!values_match("bit_slide_o", {31'd0, m_slide}, {31'd0, bit_slide_o}))
                model_errs++;
            if (!values_match("status_o", m_status, status_o))
                model_errs++;
        end
    end

    // hang guard
    always @(posedge evrClk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: stimulus did not finish within %0d cycles", MAX_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus tasks

    task automatic drive_word(rx_lane_t l);
        @(posedge evrClk);
        rx_lane_i <= l;
    endtask

    // full run of commas with random data between them, lock expected on the last
    task automatic comma_train();
        for (int i = 1; i <= COMMAS_NEEDED; i++) begin
            drive_word(comma_word());
            drive_word(data_word());    // returns on the edge that takes the comma
            if (i >= COMMAS_NEEDED - 1) begin
                @(negedge evrClk);
                if (!values_match("rx_aligned_o", {31'd0, i == COMMAS_NEEDED},
                                  {31'd0, rx_aligned_o}))
                    directed_errs++;
            end
            repeat ($urandom_range(1, 0)) drive_word(data_word());
        end
    endtask

    task automatic write_ctrl(mgt_ctrl_t v);
        logic [CSR_W-1:0] d;
        d        = $urandom;            // unused bits random
        d[30:25] = v;
        @(posedge evrClk);
        ctrl_strobe_i <= 1'b1;
        ctrl_data_i   <= d;
        @(posedge evrClk);
        ctrl_strobe_i <= 1'b0;
        ctrl_data_i   <= $urandom;      // ignored without strobe
        @(negedge evrClk);
        if (!values_match("mgt_ctrl_o", {26'd0, v}, {26'd0, mgt_ctrl_o}))
            directed_errs++;
    endtask

    task automatic expect_pulses(int exp);
        int n;
        n = 0;
        repeat (4) begin
            @(negedge evrClk);
            if (bit_slide_o) n++;
        end
        if (!values_match("slide pulses", exp, n))
            directed_errs++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        rx_lane_t  prev_word;
        rx_lane_t  next_word;
        mgt_ctrl_t ctrl_val;
        int        chk_errs;

        void'($urandom(32'h264d));
        evrClk        = 1'b0;
        arst_n_i      = 1'b0;
        rx_lane_i     = '0;
        ctrl_strobe_i = 1'b0;
        ctrl_data_i   = '0;
        mgt_stat_i    = '0;
        model_errs    = 0;
        directed_errs = 0;
        cycle_cnt     = 0;

        test_name = "reset";
        repeat (2) @(posedge evrClk);
        arst_n_i <= 1'b1;
        repeat (3) drive_word('0);      // idle, no commas yet
        @(negedge evrClk);
        if (!values_match("rx_aligned_o", 0, {31'd0, rx_aligned_o})) directed_errs++;
        if (!values_match("chars_o", 0, {12'd0, chars_o})) directed_errs++;
        if (!values_match("mgt_ctrl_o", 0, {26'd0, mgt_ctrl_o})) directed_errs++;
        if (!values_match("bit_slide_o", 0, {31'd0, bit_slide_o})) directed_errs++;

        test_name = "align_count";
        comma_train();

        test_name = "error_loss";
        drive_word(error_word());
        drive_word(data_word());
        @(negedge evrClk);
        if (!values_match("rx_aligned_o", 0, {31'd0, rx_aligned_o})) directed_errs++;
        if (!values_match("chars_o", 0, {12'd0, chars_o})) directed_errs++;
        comma_train();                  // relock needs a full run again

        test_name = "passthrough";
        prev_word = data_word();
        drive_word(prev_word);
        for (int i = 0; i < 200; i++) begin
            next_word = data_word();
            drive_word(next_word);
            @(negedge evrClk);
            if (!values_match("chars_o", {12'd0, prev_word.word}, {12'd0, chars_o}))
                directed_errs++;
            prev_word = next_word;
        end

        test_name = "ctrl_slide";
        drive_word('0);
        for (int i = 0; i < 8; i++) begin
            ctrl_val           = 6'($urandom);
            ctrl_val.slide_req = 1'b0;
            write_ctrl(ctrl_val);
            expect_pulses(0);
            ctrl_val           = 6'($urandom);
            ctrl_val.slide_req = 1'b1;
            write_ctrl(ctrl_val);
            expect_pulses(1);           // rising edge of the request
            ctrl_val           = 6'($urandom);
            ctrl_val.slide_req = 1'b1;
            write_ctrl(ctrl_val);
            expect_pulses(0);           // held high, no new slide
        end

        test_name = "status";
        for (int i = 0; i < 40; i++) begin
            if (i == 20) begin
                drive_word(error_word());   // second half unaligned
                drive_word('0);
            end
            @(posedge evrClk);
            mgt_stat_i <= 6'($urandom);
            @(negedge evrClk);
            if (!values_match("status_o", m_status, status_o)) directed_errs++;
        end

        repeat (2) @(posedge evrClk);
        chk_errs = u_dut.u_chk.fail_cnt;
        $display("errors: model %0d, directed %0d, assertions %0d",
                 model_errs, directed_errs, chk_errs);
        if (model_errs + directed_errs + chk_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* evr_rx_wrapper.f */
rtl/evr_char_pkg.sv
rtl/evr_mgt_pkg.sv
rtl/evr_rx_align.sv
rtl/evr_mgt_csr.sv
rtl/evr_rx_wrapper.sv
bench/evr_rx_wrapper_chk.sv
bench/evr_rx_wrapper_tb.sv

/* rtl/evr_char_pkg.sv */
/* Decoded 8b/10b lane types and comma framing constants for the event receiver.
   Imported by the alignment logic and the wrapper ports. */

package evr_char_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // decoded character stream

    // one two-byte word as seen by the event decoder, byte 0 in data[7:0]
    typedef struct packed {
        logic [15:0] data;      // decoded bytes
        logic [1:0]  is_k;      // per byte K flag
        logic [1:0]  is_comma;  // per byte comma flag from the decoder
    } rx_word_t;                // 20 bits

    // word plus the decoder error flags, straight from the transceiver
    typedef struct packed {
        rx_word_t    word;
        logic [1:0]  not_in_table;  // code group not valid
        logic [1:0]  disp_err;      // running disparity violation
    } rx_lane_t;                    // 24 bits

    ////////////////////////////////////////////////////////////////////////////
    // framing

    // K28.5, the only comma the event generator sends, always in byte 0
    localparam logic [7:0] K28_5 = 8'hBC;

    // clean commas in a row before the lane is trusted
    localparam int COMMAS_NEEDED = 60;

    // down counter must hold the reload value itself
    localparam int COMMA_CNT_W = $clog2(COMMAS_NEEDED + 1);

    // hunt until enough commas, drop back on any bad word
    typedef enum logic {
        ALIGN_HUNT   = 1'b0,
        ALIGN_LOCKED = 1'b1
    } align_state_t;

endpackage

/* rtl/evr_mgt_csr.sv */
/* Transceiver control register, bit slide pulse and status readback word.
   Software writes the control word by strobe and reads the status word back. */

`timescale 1ns/1ps

module evr_mgt_csr (
    input  logic                          evrClk,
    input  logic                          arst_n_i,
    input  logic                          ctrl_strobe_i,  // one cycle write
    input  logic [evr_mgt_pkg::CSR_W-1:0] ctrl_data_i,    // sampled with the strobe
    input  logic                          rx_aligned_i,
    input  evr_mgt_pkg::mgt_stat_t        mgt_stat_i,     // levels from the transceiver
    output evr_mgt_pkg::mgt_ctrl_t        mgt_ctrl_o,
    output logic                          bit_slide_o,    // single cycle pulse
    output logic [evr_mgt_pkg::CSR_W-1:0] status_o
);

    import evr_mgt_pkg::*;

    mgt_ctrl_t ctrl_q;        // stored control levels
    logic      slide_req_q;   // slide_req one cycle back

    ////////////////////////////////////////////////////////////////////////////
    // control register

    always_ff @(posedge evrClk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ctrl_q <= '0;
        end else if (ctrl_strobe_i) begin
            ctrl_q <= mgt_ctrl_t'(ctrl_data_i[CTRL_LSB +: CTRL_W]);  // bits 30..25
        end
    end

    assign mgt_ctrl_o = ctrl_q;   // slide_req mirrored too

    ////////////////////////////////////////////////////////////////////////////
    // bit slide pulse

    // rising edge of the stored request only, holding it at 1 does nothing
    always_ff @(posedge evrClk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            slide_req_q <= 1'b0;
            bit_slide_o <= 1'b0;
        end else begin
            slide_req_q <= ctrl_q.slide_req;
            bit_slide_o <= ctrl_q.slide_req && !slide_req_q;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // status readback

    always_comb begin
        status_o = '0;                                  // unused bits read zero
        status_o[ALIGNED_BIT]        = rx_aligned_i;
        status_o[STAT_LSB +: STAT_W] = mgt_stat_i;      // bits 29..24
    end

endmodule

/* rtl/evr_mgt_pkg.sv */
/* Transceiver control and status fields and their bit positions in the
   32-bit register words shared with software. */

package evr_mgt_pkg;

    // register word width on the software side
    localparam int CSR_W = 32;

    ////////////////////////////////////////////////////////////////////////////
    // control word, written by software
    //   bit 30  slide_req    bit 27  gtrxreset
    //   bit 29  gttxreset    bit 26  cpllreset
    //   bit 28  rxpmareset   bit 25  softreset (tx and rx)

    typedef struct packed {
        logic slide_req;    // rising edge asks for one bit slide
        logic gttxreset;
        logic rxpmareset;
        logic gtrxreset;
        logic cpllreset;
        logic softreset;    // drives both soft reset inputs
    } mgt_ctrl_t;

    localparam int CTRL_LSB = 25;                  // softreset position
    localparam int CTRL_W   = $bits(mgt_ctrl_t);   // 6 fields

    ////////////////////////////////////////////////////////////////////////////
    // status word, read back by software
    //   bit 30  rx aligned          bit 26  rx_fsm_reset_done
    //   bit 29  rxresetdone         bit 25  tx_fsm_reset_done
    //   bit 28  cplllock            bit 24  txresetdone
    //   bit 27  cpllfbclklost

    typedef struct packed {
        logic rxresetdone;
        logic cplllock;
        logic cpllfbclklost;
        logic rx_fsm_reset_done;
        logic tx_fsm_reset_done;
        logic txresetdone;
    } mgt_stat_t;

    localparam int STAT_LSB    = 24;                // txresetdone position
    localparam int STAT_W      = $bits(mgt_stat_t); // 6 levels
    localparam int ALIGNED_BIT = 30;                // alignment flag, above the levels

endpackage

/* rtl/evr_rx_align.sv */
/* Comma based word alignment check on the decoded receive lane.
   Only words seen while locked and error free are passed on to the event decoder. */

`timescale 1ns/1ps

module evr_rx_align (
    input  logic                   evrClk,
    input  logic                   arst_n_i,
    input  evr_char_pkg::rx_lane_t rx_lane_i,     // one decoded word per cycle
    output evr_char_pkg::rx_word_t chars_o,       // gated word, one cycle late
    output logic                   rx_aligned_o   // high while locked
);

    import evr_char_pkg::*;

    // word classification
    logic                   word_err;
    logic                   word_comma;

    // alignment fsm
    align_state_t           state_q;
    align_state_t           state_d;
    logic [COMMA_CNT_W-1:0] comma_cnt_q;
    logic [COMMA_CNT_W-1:0] comma_cnt_d;

    ////////////////////////////////////////////////////////////////////////////
    // classify the incoming word

    // any decoder flag is fatal, and K is only legal in byte 0
    assign word_err = (|rx_lane_i.not_in_table)
                   || (|rx_lane_i.disp_err)
                   || rx_lane_i.word.is_k[1];

    // a clean K28.5 in the low byte
    assign word_comma = !word_err
                     && rx_lane_i.word.is_k[0]
                     && (rx_lane_i.word.data[7:0] == K28_5);

    ////////////////////////////////////////////////////////////////////////////
    // hunt / locked state with comma down counter

    always_comb begin
        state_d     = state_q;
        comma_cnt_d = comma_cnt_q;

        if (word_err) begin
            // bad word in either state, start counting from scratch
            state_d     = ALIGN_HUNT;
            comma_cnt_d = COMMA_CNT_W'(COMMAS_NEEDED);
        end else if (state_q == ALIGN_HUNT && word_comma) begin
            comma_cnt_d = comma_cnt_q - 1'b1;
            // last comma of the run locks on this same edge
            if (comma_cnt_q == COMMA_CNT_W'(1)) begin
                state_d = ALIGN_LOCKED;
            end
        end
        // clean data words leave the count alone
    end

    always_ff @(posedge evrClk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= ALIGN_HUNT;
            comma_cnt_q <= COMMA_CNT_W'(COMMAS_NEEDED);
        end else begin
            state_q     <= state_d;
            comma_cnt_q <= comma_cnt_d;
        end
    end

    assign rx_aligned_o = (state_q == ALIGN_LOCKED);

    ////////////////////////////////////////////////////////////////////////////
    // character gating

    // decision uses the state before the edge, so the word that breaks
    // lock is already blanked
    always_ff @(posedge evrClk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            chars_o <= '0;
        end else if (state_q == ALIGN_LOCKED && !word_err) begin
            chars_o <= rx_lane_i.word;    // pass through unchanged
        end else begin
            chars_o <= '0;                // misframed or corrupt, decoder sees idle
        end
    end

endmodule

/* rtl/evr_rx_wrapper.sv */
/* Receive side of the event receiver transceiver wrapper.
   Joins lane alignment with the software control and status register. */

`timescale 1ns/1ps

module evr_rx_wrapper (
    input  logic                          evrClk,        // recovered lane clock
    input  logic                          arst_n_i,
    // decoded lane from the transceiver
    input  evr_char_pkg::rx_lane_t        rx_lane_i,
    // software control write
    input  logic                          ctrl_strobe_i,
    input  logic [evr_mgt_pkg::CSR_W-1:0] ctrl_data_i,
    // transceiver status levels
    input  evr_mgt_pkg::mgt_stat_t        mgt_stat_i,
    // to the event decoder
    output evr_char_pkg::rx_word_t        chars_o,
    output logic                          rx_aligned_o,
    // to the transceiver
    output evr_mgt_pkg::mgt_ctrl_t        mgt_ctrl_o,
    output logic                          bit_slide_o,
    // software readback
    output logic [evr_mgt_pkg::CSR_W-1:0] status_o
);

    logic rx_aligned;   // lock flag, also shown in the status word

    // comma alignment and character gating
    evr_rx_align u_align (
        .evrClk       (evrClk),
        .arst_n_i     (arst_n_i),
        .rx_lane_i    (rx_lane_i),
        .chars_o      (chars_o),
        .rx_aligned_o (rx_aligned)
    );

    // control bits, slide pulse, status word
    evr_mgt_csr u_csr (
        .evrClk        (evrClk),
        .arst_n_i      (arst_n_i),
        .ctrl_strobe_i (ctrl_strobe_i),
        .ctrl_data_i   (ctrl_data_i),
        .rx_aligned_i  (rx_aligned),
        .mgt_stat_i    (mgt_stat_i),
        .mgt_ctrl_o    (mgt_ctrl_o),
        .bit_slide_o   (bit_slide_o),
        .status_o      (status_o)
    );

    assign rx_aligned_o = rx_aligned;

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the evr_rx_wrapper testbench with Verilator.
set -e
cd "$(dirname "$0")"

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module evr_rx_wrapper_tb \
    -f evr_rx_wrapper.f \
    -o sim_evr_rx_wrapper

# a failing run still leaves its log to judge
./obj_dir/sim_evr_rx_wrapper +verilator+error+limit+1000 > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "all tests passed" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
